// ==== build.f ====
ntps_time_pkg.sv
ntps_path_pkg.sv
ntps_time_select.sv
ntps_network_path.sv
ntps_response_mux.sv
ntps_top.sv
tb_ntps_top.sv

// ==== ntps_network_path.sv ====
// One network path reduced to SFP status and a single request slot
// A request arriving while a response is pending is dropped

`timescale 1ns/1ps

module ntps_network_path
  import ntps_time_pkg::*;
  import ntps_path_pkg::*;
(
  input  logic      clk156,
  input  logic      rst_n,
  input  ntp_time_t cur_time,
  input  logic      time_valid,
  input  logic      module_detect_n,
  input  logic      signal_lost,
  input  logic      tx_fault,
  input  logic      req,
  input  ntp_time_t req_origin,
  input  logic      grant,
  output logic      tx_disable,
  output logic      resp_pending,
  output ntp_time_t resp_origin,
  output ntp_time_t resp_rx_time
);

  path_state_t state_q;
  path_state_t state_next;
  logic        link_up;
  logic        accept;

  //----------------------------------------------------------
  // SFP link status
  //----------------------------------------------------------
  assign link_up = !module_detect_n && !signal_lost && !tx_fault;

  // Transmitter stays off until a module is present and healthy
  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      tx_disable <= 1'b1;
    end else begin
      tx_disable <= module_detect_n | tx_fault;
    end
  end

  //----------------------------------------------------------
  // Request slot
  //----------------------------------------------------------
  assign accept = req && (state_q == PATH_IDLE) && link_up && time_valid;

  always_comb begin
    state_next = state_q;
    case (state_q)
      PATH_IDLE: begin
        if (accept) begin
          state_next = PATH_PENDING;
        end
      end
      PATH_PENDING: begin
        if (grant) begin
          state_next = PATH_IDLE;
        end
      end
      default: begin
        state_next = PATH_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      state_q <= PATH_IDLE;
    end else begin
      state_q <= state_next;
    end
  end

  // Receive timestamp taken in the request cycle
  always_ff @(posedge clk156) begin
    if (accept) begin
      resp_origin  <= req_origin;
      resp_rx_time <= cur_time;
    end
  end

  assign resp_pending = (state_q == PATH_PENDING);

  a_grant_when_pending : assert property (@(posedge clk156) disable iff (!rst_n)
    grant |-> (state_q == PATH_PENDING));

endmodule

// ==== ntps_path_pkg.sv ====
// Network path count and path indexing types
// N_PATHS must be a power of two, the collector pointer wraps by overflow

package ntps_path_pkg;

  //----------------------------------------------------------
  // Path count and derived widths
  //----------------------------------------------------------
  localparam int N_PATHS   = 4;
  localparam int PATH_ID_W = $clog2(N_PATHS);

  typedef logic [PATH_ID_W-1:0] path_id_t;

  // One bit per network path
  typedef logic [N_PATHS-1:0] path_mask_t;

  // Per-path response state
  typedef enum logic {
    PATH_IDLE    = 1'b0,
    PATH_PENDING = 1'b1
  } path_state_t;

endpackage

// ==== ntps_response_mux.sv ====
// Round-robin collector for the pending path responses
// Grants at most one path per cycle, the output strobe has no ready

`timescale 1ns/1ps

module ntps_response_mux
  import ntps_time_pkg::*;
  import ntps_path_pkg::*;
(
  input  logic       clk156,
  input  logic       rst_n,
  input  ntp_time_t  cur_time,
  input  path_mask_t resp_pending,
  input  ntp_time_t  path_origin [N_PATHS],
  input  ntp_time_t  path_rx_time [N_PATHS],
  output path_mask_t grant,
  output logic       resp_valid,
  output path_id_t   resp_path,
  output ntp_time_t  resp_origin,
  output ntp_time_t  resp_rx_time,
  output ntp_time_t  resp_tx_time
);

  path_id_t ptr_q;
  path_id_t winner;
  logic     found;

  //----------------------------------------------------------
  // Search from the pointer for the first pending path
  //----------------------------------------------------------
  always_comb begin
    path_id_t idx;
    found  = 1'b0;
    winner = ptr_q;
    for (int i = 0; i < N_PATHS; i++) begin
      // Index wraps by overflow of the path id
      idx = ptr_q + path_id_t'(i);
      if (!found && resp_pending[idx]) begin
        found  = 1'b1;
        winner = idx;
      end
    end
  end

  assign grant = found ? (path_mask_t'(1) << winner) : '0;

  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      ptr_q      <= '0;
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= found;
      if (found) begin
        ptr_q <= winner + path_id_t'(1);
      end
    end
  end

  //----------------------------------------------------------
  // Response register, transmit time is the grant cycle time
  //----------------------------------------------------------
  always_ff @(posedge clk156) begin
    if (found) begin
      resp_path    <= winner;
      resp_origin  <= path_origin[winner];
      resp_rx_time <= path_rx_time[winner];
      resp_tx_time <= cur_time;
    end
  end

  a_grant_onehot : assert property (@(posedge clk156) disable iff (!rst_n)
    (|resp_pending) |-> $onehot(grant));

  a_grant_subset : assert property (@(posedge clk156) disable iff (!rst_n)
    (grant & ~resp_pending) == '0);

endmodule

// ==== ntps_time_pkg.sv ====
// NTP time types shared by the selector, the paths and the collector
// Timestamps are 32.32 fixed point, seconds above fraction

package ntps_time_pkg;

  //----------------------------------------------------------
  // Field widths
  //----------------------------------------------------------
  localparam int NTP_SEC_W  = 32;
  localparam int NTP_FRAC_W = 32;

  typedef logic [NTP_SEC_W-1:0]  ntp_sec_t;
  typedef logic [NTP_FRAC_W-1:0] ntp_frac_t;

  // Full timestamp, seconds in the upper half
  typedef logic [$bits(ntp_sec_t)+$bits(ntp_frac_t)-1:0] ntp_time_t;

  // Reference source currently driving the server time
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_A    = 2'd1,
    SRC_B    = 2'd2
  } time_src_t;

endpackage

// ==== ntps_time_select.sv ====
// Selects reference A over B by sync status and holds the server time
// cur_time only moves on an update strobe from the selected source

`timescale 1ns/1ps

module ntps_time_select
  import ntps_time_pkg::*;
(
  input  logic      clk156,
  input  logic      rst_n,
  input  ntp_time_t ntp_time_a,
  input  logic      ntp_time_upd_a,
  input  logic      ntp_sync_ok_a,
  input  ntp_time_t ntp_time_b,
  input  logic      ntp_time_upd_b,
  input  logic      ntp_sync_ok_b,
  output ntp_time_t cur_time,
  output logic      time_valid
);

  time_src_t src_q;
  time_src_t src_next;
  logic      loaded_q;
  logic      upd_sel;
  ntp_time_t time_sel;

  //----------------------------------------------------------
  // Source priority, A wins while it is in sync
  //----------------------------------------------------------
  always_comb begin
    if (ntp_sync_ok_a) begin
      src_next = SRC_A;
    end else if (ntp_sync_ok_b) begin
      src_next = SRC_B;
    end else begin
      src_next = SRC_NONE;
    end
  end

  // Update strobe and time of the current source
  always_comb begin
    upd_sel  = 1'b0;
    time_sel = ntp_time_a;
    case (src_q)
      SRC_A: begin
        upd_sel  = ntp_time_upd_a;
        time_sel = ntp_time_a;
      end
      SRC_B: begin
        upd_sel  = ntp_time_upd_b;
        time_sel = ntp_time_b;
      end
      default: begin
        upd_sel = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk156) begin
    if (!rst_n) begin
      src_q    <= SRC_NONE;
      loaded_q <= 1'b0;
      cur_time <= '0;
    end else begin
      src_q <= src_next;
      if (upd_sel) begin
        cur_time <= time_sel;
        loaded_q <= 1'b1;
      end
    end
  end

  // Sticky load flag, valid drops only with the source
  assign time_valid = loaded_q && (src_q != SRC_NONE);

  a_valid_has_src : assert property (@(posedge clk156) disable iff (!rst_n)
    time_valid |-> $past(ntp_sync_ok_a || ntp_sync_ok_b));

  a_time_moves_on_upd : assert property (@(posedge clk156) disable iff (!rst_n)
    !$stable(cur_time) |-> $past(ntp_time_upd_a || ntp_time_upd_b));

endmodule

// ==== ntps_top.sv ====
// NTP server core with time selection, four network paths and a collector
// All logic runs on clk156 with a synchronous active low reset

`timescale 1ns/1ps

module ntps_top
  import ntps_time_pkg::*;
  import ntps_path_pkg::*;
(
  input  logic       clk156,
  input  logic       rst_n,
  input  ntp_time_t  ntp_time_a,
  input  logic       ntp_time_upd_a,
  input  logic       ntp_sync_ok_a,
  input  ntp_time_t  ntp_time_b,
  input  logic       ntp_time_upd_b,
  input  logic       ntp_sync_ok_b,
  input  path_mask_t module_detect_n,
  input  path_mask_t signal_lost,
  input  path_mask_t tx_fault,
  input  path_mask_t req,
  input  ntp_time_t  req_origin [N_PATHS],
  output path_mask_t tx_disable,
  output ntp_time_t  ntp_time,
  output logic       time_valid,
  output logic       resp_valid,
  output path_id_t   resp_path,
  output ntp_time_t  resp_origin,
  output ntp_time_t  resp_rx_time,
  output ntp_time_t  resp_tx_time
);

  path_mask_t path_pending;
  path_mask_t path_grant;
  ntp_time_t  path_origin [N_PATHS];
  ntp_time_t  path_rx_time [N_PATHS];

  //----------------------------------------------------------
  // Reference time selection
  //----------------------------------------------------------
  ntps_time_select time_select (
    .clk156         (clk156),
    .rst_n          (rst_n),
    .ntp_time_a     (ntp_time_a),
    .ntp_time_upd_a (ntp_time_upd_a),
    .ntp_sync_ok_a  (ntp_sync_ok_a),
    .ntp_time_b     (ntp_time_b),
    .ntp_time_upd_b (ntp_time_upd_b),
    .ntp_sync_ok_b  (ntp_sync_ok_b),
    .cur_time       (ntp_time),
    .time_valid     (time_valid)
  );

  //----------------------------------------------------------
  // Network paths
  //----------------------------------------------------------
  for (genvar i = 0; i < N_PATHS; i++) begin : g_path
    ntps_network_path network_path (
      .clk156          (clk156),
      .rst_n           (rst_n),
      .cur_time        (ntp_time),
      .time_valid      (time_valid),
      .module_detect_n (module_detect_n[i]),
      .signal_lost     (signal_lost[i]),
      .tx_fault        (tx_fault[i]),
      .req             (req[i]),
      .req_origin      (req_origin[i]),
      .grant           (path_grant[i]),
      .tx_disable      (tx_disable[i]),
      .resp_pending    (path_pending[i]),
      .resp_origin     (path_origin[i]),
      .resp_rx_time    (path_rx_time[i])
    );
  end

  // Response collector
  ntps_response_mux response_mux (
    .clk156       (clk156),
    .rst_n        (rst_n),
    .cur_time     (ntp_time),
    .resp_pending (path_pending),
    .path_origin  (path_origin),
    .path_rx_time (path_rx_time),
    .grant        (path_grant),
    .resp_valid   (resp_valid),
    .resp_path    (resp_path),
    .resp_origin  (resp_origin),
    .resp_rx_time (resp_rx_time),
    .resp_tx_time (resp_tx_time)
  );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the NTP server testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_ntps_top -Mdir obj_dir \
  && ./obj_dir/Vtb_ntps_top | tee sim.log \
  && grep -q "ALL TESTS PASSED" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

// ==== tb_ntps_top.sv ====
// Self-checking testbench for the NTP server core
// The cycle model is evaluated on the falling edge, where inputs and outputs are stable

`timescale 1ns/1ps

module tb_ntps_top
  import ntps_time_pkg::*;
  import ntps_path_pkg::*;
();

  localparam int MAX_CYCLES = 4000;

  // Accepted request waiting for its response
  typedef struct packed {
    path_id_t    path;
    ntp_time_t   origin;
    ntp_time_t   rx;
    logic [31:0] cyc;
  } pend_req_t;

  logic       clk156;
  logic       rst_n;
  ntp_time_t  ntp_time_a;
  logic       ntp_time_upd_a;
  logic       ntp_sync_ok_a;
  ntp_time_t  ntp_time_b;
  logic       ntp_time_upd_b;
  logic       ntp_sync_ok_b;
  path_mask_t module_detect_n;
  path_mask_t signal_lost;
  path_mask_t tx_fault;
  path_mask_t req;
  ntp_time_t  req_origin [N_PATHS];
  path_mask_t tx_disable;
  ntp_time_t  ntp_time;
  logic       time_valid;
  logic       resp_valid;
  path_id_t   resp_path;
  ntp_time_t  resp_origin;
  ntp_time_t  resp_rx_time;
  ntp_time_t  resp_tx_time;

  // Reference model state
  time_src_t  m_src;
  logic       m_loaded;
  ntp_time_t  m_time;
  path_mask_t m_txdis;
  path_mask_t m_pend;
  path_id_t   m_ptr;
  logic       m_rv;
  path_id_t   m_rpath;
  ntp_time_t  m_rtx;
  pend_req_t  exp_q [$];

  int   errors = 0;
  int   seq_errors = 0;
  int   resp_count = 0;
  int   cycles = 0;
  logic time_run;

  ntps_top UUT (.*);

  initial begin
    clk156 = 1'b0;
    forever #5 clk156 = ~clk156;
  end

  //----------------------------------------------------------
  // Reference model of the selector
  //----------------------------------------------------------
  function automatic time_src_t ref_src(logic sync_a, logic sync_b);
    if (sync_a) begin
      return SRC_A;
    end
    if (sync_b) begin
      return SRC_B;
    end
    return SRC_NONE;
  endfunction

  // Update strobe of the selected source only
  function automatic logic ref_load(time_src_t src, logic upd_a, logic upd_b);
    return ((src == SRC_A) && upd_a) || ((src == SRC_B) && upd_b);
  endfunction

  task automatic check_time(string name, ntp_time_t got, ntp_time_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_path(string name, path_id_t got, path_id_t exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  //----------------------------------------------------------
  // Compare against the model, then advance it one cycle
  //----------------------------------------------------------
  always @(negedge clk156) begin
    path_mask_t link;
    path_mask_t acc;
    path_mask_t gnt;
    path_id_t   idx;
    logic       found;
    logic       valid;
    int         hit;
    if (!rst_n) begin
      m_src    = SRC_NONE;
      m_loaded = 1'b0;
      m_time   = '0;
      m_txdis  = '1;
      m_pend   = '0;
      m_ptr    = '0;
      m_rv     = 1'b0;
      exp_q.delete();
    end else begin
      valid = m_loaded && (m_src != SRC_NONE);
      check_time("ntp_time", ntp_time, m_time);
      check_bit("time_valid", time_valid, valid);
      for (int i = 0; i < N_PATHS; i++) begin
        check_bit($sformatf("tx_disable[%0d]", i), tx_disable[i], m_txdis[i]);
      end
      check_bit("resp_valid", resp_valid, m_rv);
      if (resp_valid === 1'b1) begin
        resp_count++;
      end
      if (m_rv && (resp_valid === 1'b1)) begin
        hit = -1;
        for (int k = 0; k < exp_q.size(); k++) begin
          if (exp_q[k].path == m_rpath) begin
            hit = k;
          end
        end
        check_path("resp_path", resp_path, m_rpath);
        check_time("resp_tx_time", resp_tx_time, m_rtx);
        if (hit < 0) begin
          errors++;
          $display("Response on path %0d has no accepted request", m_rpath);
        end else begin
          check_time("resp_origin", resp_origin, exp_q[hit].origin);
          check_time("resp_rx_time", resp_rx_time, exp_q[hit].rx);
          if (cycles - int'(exp_q[hit].cyc) < 2) begin
            errors++;
            $display("Response on path %0d came sooner than 2 cycles", m_rpath);
          end
          exp_q.delete(hit);
        end
      end
      // Accepts and the round-robin grant
      link  = ~module_detect_n & ~signal_lost & ~tx_fault;
      acc   = req & ~m_pend & link & {N_PATHS{valid}};
      gnt   = '0;
      found = 1'b0;
      for (int k = 0; k < N_PATHS; k++) begin
        idx = m_ptr + path_id_t'(k);
        if (!found && m_pend[idx]) begin
          found    = 1'b1;
          gnt[idx] = 1'b1;
          m_rpath  = idx;
        end
      end
      m_rv = found;
      if (found) begin
        m_rtx = m_time;
        m_ptr = m_rpath + path_id_t'(1);
      end
      for (int i = 0; i < N_PATHS; i++) begin
        if (acc[i]) begin
          exp_q.push_back(pend_req_t'{path: path_id_t'(i), origin: req_origin[i],
                                      rx: m_time, cyc: 32'(cycles)});
        end
      end
      m_pend  = (m_pend & ~gnt) | acc;
      m_txdis = module_detect_n | tx_fault;
      if (ref_load(m_src, ntp_time_upd_a, ntp_time_upd_b)) begin
        m_time   = (m_src == SRC_A) ? ntp_time_a : ntp_time_b;
        m_loaded = 1'b1;
      end
      m_src = ref_src(ntp_sync_ok_a, ntp_sync_ok_b);
    end
  end

  always @(posedge clk156) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, errors: %0d", cycles, errors + seq_errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  //----------------------------------------------------------
  // Stimulus helpers
  //----------------------------------------------------------
  // Strobes last one cycle, reference A ticks while time_run is set
  task automatic next_cycle();
    @(posedge clk156);
    #1;
    ntp_time_upd_a = time_run;
    ntp_time_upd_b = 1'b0;
    req            = '0;
    if (time_run) begin
      ntp_time_a = ntp_time_a + 64'h0000_0000_0123_4567;
    end
  endtask

  task automatic wait_response(string what, int limit);
    int n;
    n = 0;
    while ((resp_valid !== 1'b1) && (n < limit)) begin
      next_cycle();
      n++;
    end
    if (resp_valid !== 1'b1) begin
      seq_errors++;
      $display("%s: no response within %0d cycles", what, limit);
    end
  endtask

  task automatic expect_count(string what, int base, int n);
    if (resp_count - base != n) begin
      seq_errors++;
      $display("%s: %0d responses, expected %0d", what, resp_count - base, n);
    end
  endtask

  initial begin
    int base;
    void'($urandom(32'h6a14fa74));
    rst_n           = 1'b0;
    time_run        = 1'b0;
    ntp_time_a      = '0;
    ntp_time_upd_a  = 1'b0;
    ntp_sync_ok_a   = 1'b0;
    ntp_time_b      = '0;
    ntp_time_upd_b  = 1'b0;
    ntp_sync_ok_b   = 1'b0;
    module_detect_n = '1;
    signal_lost     = '1;
    tx_fault        = '0;
    req             = '0;
    for (int i = 0; i < N_PATHS; i++) begin
      req_origin[i] = '0;
    end
    repeat (4) next_cycle();
    rst_n = 1'b1;

    // Source priority, directed then random
    ntp_time_a     = {$urandom, $urandom};
    ntp_time_upd_a = 1'b1;
    next_cycle();
    ntp_sync_ok_b = 1'b1;
    next_cycle();
    ntp_time_b     = {$urandom, $urandom};
    ntp_time_upd_b = 1'b1;
    next_cycle();
    ntp_sync_ok_a = 1'b1;
    next_cycle();
    ntp_time_upd_b = 1'b1;
    next_cycle();
    ntp_time_upd_a = 1'b1;
    next_cycle();
    ntp_sync_ok_a = 1'b0;
    ntp_sync_ok_b = 1'b0;
    repeat (3) next_cycle();
    repeat (800) begin
      ntp_sync_ok_a  = 1'($urandom);
      ntp_sync_ok_b  = 1'($urandom);
      ntp_time_a     = {$urandom, $urandom};
      ntp_time_b     = {$urandom, $urandom};
      ntp_time_upd_a = 1'($urandom);
      ntp_time_upd_b = 1'($urandom);
      next_cycle();
    end
    ntp_sync_ok_a = 1'b1;
    ntp_sync_ok_b = 1'b0;
    time_run      = 1'b1;
    next_cycle();

    // Random link inputs with random request traffic
    repeat (800) begin
      module_detect_n = path_mask_t'($urandom) & path_mask_t'($urandom);
      signal_lost     = path_mask_t'($urandom) & path_mask_t'($urandom);
      tx_fault        = path_mask_t'($urandom) & path_mask_t'($urandom);
      req             = path_mask_t'($urandom) & path_mask_t'($urandom);
      for (int i = 0; i < N_PATHS; i++) begin
        req_origin[i] = {$urandom, $urandom};
      end
      next_cycle();
    end
    module_detect_n = '0;
    signal_lost     = '0;
    tx_fault        = '0;
    repeat (12) next_cycle();

    // Single request on path 2
    base          = resp_count;
    req[2]        = 1'b1;
    req_origin[2] = {$urandom, $urandom};
    next_cycle();
    wait_response("single request", 20);
    repeat (12) next_cycle();
    expect_count("single request", base, 1);

    // Link down, time invalid, then a repeat while pending
    base           = resp_count;
    signal_lost[1] = 1'b1;
    req[1]         = 1'b1;
    next_cycle();
    signal_lost[1] = 1'b0;
    ntp_sync_ok_a  = 1'b0;
    next_cycle();
    req[0] = 1'b1;
    next_cycle();
    ntp_sync_ok_a = 1'b1;
    repeat (3) next_cycle();
    req[1] = 1'b1;
    next_cycle();
    req[1] = 1'b1;
    next_cycle();
    repeat (12) next_cycle();
    expect_count("dropped requests", base, 1);

    // All paths at once, order follows the pointer
    repeat (2) begin
      base = resp_count;
      req  = '1;
      for (int i = 0; i < N_PATHS; i++) begin
        req_origin[i] = {$urandom, $urandom};
      end
      next_cycle();
      wait_response("simultaneous requests", 20);
      repeat (12) next_cycle();
      expect_count("simultaneous requests", base, N_PATHS);
    end

    if (exp_q.size() != 0) begin
      seq_errors++;
      $display("%0d accepted requests were never answered", exp_q.size());
    end
    $display("Compare errors: %0d, sequence errors: %0d, responses: %0d, cycles: %0d",
             errors, seq_errors, resp_count, cycles);
    if ((errors == 0) && (seq_errors == 0)) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule
